//--- hw/prach_pkg.sv
package prach_pkg;

  // Carrier and antenna layout
  localparam int NUM_CC  = 2;
  localparam int NUM_ANT = 2;
  localparam int NUM_BUF = NUM_CC * NUM_ANT;  // One capture buffer per carrier and antenna

  // Buffer geometry
  localparam int SEG_NUM   = 3;                      // Segments read in turn per index
  localparam int SEG_BITS  = 2;                      // Segment field of the read counter
  localparam int IDX_BITS  = 3;                      // Samples per segment is 2**IDX_BITS
  localparam int ADDR_BITS = IDX_BITS + SEG_BITS;
  localparam int FRAME_LEN = SEG_NUM * (2 ** IDX_BITS);

  localparam int BUF_SEL_BITS = $clog2(NUM_BUF);

  // Read address to FFT output sample, one cycle in the buffer and one in the output register
  localparam int OUT_DELAY = 2;

  // Complex sample word, imaginary part in the upper half
  typedef struct packed {
    logic signed [15:0] im;
    logic signed [15:0] re;
  } iq_sample_t;

  // Capture input, broadcast to every buffer
  typedef struct packed {
    logic                    valid;
    logic [BUF_SEL_BITS-1:0] buf_sel;  // carrier * NUM_ANT + antenna
    iq_sample_t              sample;
  } cap_sample_t;

  // FFT-ready output stream
  typedef struct packed {
    logic       dv;
    logic       sync;  // High with the sample at address zero
    iq_sample_t sample;
  } fft_out_t;

endpackage

//--- hw/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
  parameter int WIDTH = 1,
  parameter int DELAY = 2
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  logic [WIDTH-1:0] stage [DELAY];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DELAY; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= din;
      for (int i = 1; i < DELAY; i++) begin
        stage[i] <= stage[i-1];  // Shift one stage per clock
      end
    end
  end

  assign dout = stage[DELAY-1];

endmodule

//--- hw/prach_capture_buffer.sv
`timescale 1ns/1ps

module prach_capture_buffer
  import prach_pkg::*;
#(
  parameter int BUF_ID = 0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cap_sample_t          cap_in,
  output logic                 done_req,
  input  logic                 done_ack,
  input  logic [ADDR_BITS-1:0] rd_addr,
  output iq_sample_t           rd_data
);

  iq_sample_t           mem [2**ADDR_BITS];

  logic [ADDR_BITS-1:0] wr_cnt;
  logic                 wr_en;
  logic                 last_wr;
  logic                 full;
  logic                 granted;
  logic                 ack_fall;

  iq_sample_t           rd_q;
  logic                 rd_en_q;

  // Only samples tagged for this buffer are taken, and none while full
  assign wr_en   = cap_in.valid && (cap_in.buf_sel == BUF_SEL_BITS'(BUF_ID)) && !full;
  assign last_wr = (wr_cnt == ADDR_BITS'(FRAME_LEN - 1));

  // Ack was high and has dropped, so this frame is fully read
  assign ack_fall = granted && !done_ack;

  // Request drops in the same cycle the ack falls so the arbiter cannot grant us twice
  assign done_req = full && !ack_fall;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_cnt  <= '0;
      full    <= 1'b0;
      granted <= 1'b0;
    end else if (ack_fall) begin
      wr_cnt  <= '0;    // Start filling the next frame
      full    <= 1'b0;
      granted <= 1'b0;
    end else begin
      if (done_ack) begin
        granted <= 1'b1;
      end
      if (wr_en) begin
        wr_cnt <= wr_cnt + 1'b1;
        if (last_wr) begin
          full <= 1'b1;
        end
      end
    end
  end

  // Fill count maps straight onto the segment and index address
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_cnt] <= cap_in.sample;
    end
  end

  always_ff @(posedge clk) begin
    rd_q <= mem[rd_addr];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_en_q <= 1'b0;
    end else begin
      rd_en_q <= done_ack;  // Read enable follows the address by one cycle like the data
    end
  end

  // Idle buffers put zero on the bus so the readout block can OR all words
  assign rd_data = rd_en_q ? rd_q : '0;

endmodule

//--- hw/prach_buffer_readout.sv
`timescale 1ns/1ps

module prach_buffer_readout
  import prach_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [NUM_BUF-1:0]   done_req,
  output logic [NUM_BUF-1:0]   done_ack,
  output logic [ADDR_BITS-1:0] rd_addr,
  input  iq_sample_t           rd_data [NUM_BUF],
  output fft_out_t             fft_out
);

  localparam logic [ADDR_BITS-1:0] LAST_CNT = {{IDX_BITS{1'b1}}, SEG_BITS'(SEG_NUM - 1)};

  logic                 busy;
  logic                 done;
  logic                 any_req;
  logic                 found;
  logic [NUM_BUF-1:0]   win;
  logic [NUM_BUF-1:0]   ack;

  logic [ADDR_BITS-1:0] rd_cnt;
  logic [ADDR_BITS-1:0] rd_cnt_next;
  logic                 addr_zero;

  iq_sample_t           rd_or;
  iq_sample_t           sample_q;
  logic                 dv_d;
  logic                 sync_d;

  assign any_req = |done_req;

  // First channel first, the lowest requesting index wins
  always_comb begin
    win   = '0;
    found = 1'b0;
    for (int i = 0; i < NUM_BUF; i++) begin
      if (done_req[i] && !found) begin
        win[i] = 1'b1;
        found  = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack <= '0;
    end else if (busy && done) begin
      ack <= '0;
    end else if (!busy) begin
      ack <= win;  // Grant is held for the whole frame
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (busy) begin
      busy <= !done;
    end else begin
      busy <= any_req;
    end
  end

  assign done_ack = ack;

  // Segment in the low bits steps fastest, index above it
  always_comb begin
    if (rd_cnt[SEG_BITS-1:0] == SEG_BITS'(SEG_NUM - 1)) begin
      rd_cnt_next = {rd_cnt[ADDR_BITS-1:SEG_BITS] + 1'b1, {SEG_BITS{1'b0}}};
    end else begin
      rd_cnt_next = rd_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || !busy) begin
      rd_cnt <= '0;
    end else begin
      rd_cnt <= rd_cnt_next;
    end
  end

  assign done = (rd_cnt == LAST_CNT);

  // Segment goes on top and the index below it bit-reversed
  always_comb begin
    rd_addr[ADDR_BITS-1 -: SEG_BITS] = rd_cnt[SEG_BITS-1:0];
    for (int i = 0; i < IDX_BITS; i++) begin
      rd_addr[i] = rd_cnt[ADDR_BITS-1-i];
    end
  end

  assign addr_zero = busy && (rd_addr == '0);

  // Only the granted buffer drives a nonzero word
  always_comb begin
    rd_or = '0;
    for (int i = 0; i < NUM_BUF; i++) begin
      rd_or = rd_or | rd_data[i];
    end
  end

  always_ff @(posedge clk) begin
    sample_q <= rd_or;
  end

  delay_line #(
    .WIDTH(1),
    .DELAY(OUT_DELAY)
  ) u_dv_delay (
    .clk  (clk),
    .rst_n(rst_n),
    .din  (busy),
    .dout (dv_d)
  );

  delay_line #(
    .WIDTH(1),
    .DELAY(OUT_DELAY)
  ) u_sync_delay (
    .clk  (clk),
    .rst_n(rst_n),
    .din  (addr_zero),
    .dout (sync_d)
  );

  assign fft_out = '{dv: dv_d, sync: sync_d, sample: sample_q};

endmodule

//--- hw/prach_readout_top.sv
`timescale 1ns/1ps

module prach_readout_top
  import prach_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  cap_sample_t cap_in,
  output fft_out_t    fft_out
);

  logic [NUM_BUF-1:0]   done_req;
  logic [NUM_BUF-1:0]   done_ack;
  logic [ADDR_BITS-1:0] rd_addr;
  iq_sample_t           rd_data [NUM_BUF];

  // One buffer per carrier and antenna, numbered carrier-major
  for (genvar cc = 0; cc < NUM_CC; cc++) begin : g_cc
    for (genvar ant = 0; ant < NUM_ANT; ant++) begin : g_ant

      prach_capture_buffer #(
        .BUF_ID(cc * NUM_ANT + ant)
      ) u_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .cap_in  (cap_in),
        .done_req(done_req[cc*NUM_ANT+ant]),
        .done_ack(done_ack[cc*NUM_ANT+ant]),
        .rd_addr (rd_addr),
        .rd_data (rd_data[cc*NUM_ANT+ant])
      );

    end
  end

  prach_buffer_readout u_readout (
    .clk     (clk),
    .rst_n   (rst_n),
    .done_req(done_req),
    .done_ack(done_ack),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .fft_out (fft_out)
  );

endmodule

//--- dv/prach_readout_checker.sv
`timescale 1ns/1ps

module prach_readout_checker
  import prach_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input fft_out_t fft_out
);

  iq_sample_t exp_sample_q [$];
  logic       exp_sync_q [$];

  int err_cnt;
  int checked_cnt;
  int run_len;  // Length of the current dv burst

  initial begin
    err_cnt     = 0;
    checked_cnt = 0;
    run_len     = 0;
  end

  task automatic expect_sample(input iq_sample_t s, input logic sync);
    exp_sample_q.push_back(s);
    exp_sync_q.push_back(sync);
  endtask

  function automatic int pending();
    return exp_sample_q.size();
  endfunction

  always @(posedge clk) begin : watch
    iq_sample_t exp_s;
    logic       exp_y;
    if (rst_n) begin
      if (fft_out.dv) begin
        run_len++;
        if (exp_sample_q.size() == 0) begin
          $display("error at %0t: output sample %h arrived while no frame was expected",
                   $time, fft_out.sample);
          err_cnt++;
        end else begin
          exp_s = exp_sample_q.pop_front();
          exp_y = exp_sync_q.pop_front();
          checked_cnt++;
          if (fft_out.sample !== exp_s) begin
            $display("mismatch at %0t: fft_out.sample expected %h got %h",
                     $time, exp_s, fft_out.sample);
            err_cnt++;
          end
          if (fft_out.sync !== exp_y) begin
            $display("mismatch at %0t: fft_out.sync expected %0b got %0b",
                     $time, exp_y, fft_out.sync);
            err_cnt++;
          end
        end
      end else begin
        if (fft_out.sync !== 1'b0) begin
          $display("error at %0t: sync was high while dv was low", $time);
          err_cnt++;
        end
        if (run_len != 0 && run_len != FRAME_LEN) begin  // Gaps or long bursts break a frame
          $display("mismatch at %0t: fft_out.dv run length expected %0d got %0d",
                   $time, FRAME_LEN, run_len);
          err_cnt++;
        end
        run_len = 0;
      end
    end
  end

endmodule

//--- dv/prach_readout_tb.sv
`timescale 1ns/1ps

module prach_readout_tb
  import prach_pkg::*;
();

  localparam string GOLDEN_FILE  = "dv/prach_golden.txt";
  localparam int    QUIET_CYCLES = FRAME_LEN + 8;
  localparam int    IDX_COUNT    = 2 ** IDX_BITS;
  localparam int    SPARE_WORDS  = 2 ** ADDR_BITS - FRAME_LEN;

  logic        clk;
  logic        rst_n;
  cap_sample_t cap_in;
  fft_out_t    fft_out;

  int   tests_run;
  int   tests_failed;
  logic aborted;

  prach_readout_top dut_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .cap_in (cap_in),
    .fft_out(fft_out)
  );

  prach_readout_checker chk_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .fft_out(fft_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int bit_reverse(input int v);
    int r;
    r = 0;
    for (int i = 0; i < IDX_BITS; i++) begin
      r = (r << 1) | ((v >> i) & 1);
    end
    return r;
  endfunction

  // Real part of write w into buffer b
  function automatic logic [15:0] sample_re(input logic [15:0] base, input int b, input int w);
    return 16'(int'(base) + b * 64 + w);
  endfunction

  task automatic drive_write(input int b, input logic [15:0] re);
    cap_sample_t c;
    c.valid     = 1'b1;
    c.buf_sel   = BUF_SEL_BITS'(b);
    c.sample.re = re;
    c.sample.im = ~re;
    @(posedge clk);
    cap_in <= c;
  endtask

  // Segments in turn for each bit-reversed index
  task automatic push_frame(input int b, input logic [15:0] base);
    iq_sample_t s;
    int         w;
    for (int idx = 0; idx < IDX_COUNT; idx++) begin
      for (int seg = 0; seg < SEG_NUM; seg++) begin
        w    = seg * IDX_COUNT + bit_reverse(idx);
        s.re = sample_re(base, b, w);
        s.im = ~s.re;
        chk_i.expect_sample(s, idx == 0 && seg == 0);
      end
    end
  endtask

  task automatic wait_drained(input int limit, output logic ok);
    int cyc;
    cyc = 0;
    ok  = 1'b0;
    while (!ok && cyc < limit) begin
      @(negedge clk);
      ok = (chk_i.pending() == 0);
      cyc++;
    end
  endtask

  task automatic run_test(input string name, input logic [NUM_BUF-1:0] mask, input int lead,
                          input int drop, input logic [15:0] base, input int grant [4]);
    int   frames;
    int   err_before;
    int   limit;
    logic drained;
    err_before = chk_i.err_cnt;
    frames     = 0;
    for (int i = 0; i < 4; i++) begin
      if (grant[i] < NUM_BUF) begin
        push_frame(grant[i], base);
        frames++;
      end
    end
    for (int w = 0; w < FRAME_LEN; w++) begin
      if (w == FRAME_LEN - 1 && lead < NUM_BUF) begin  // Others fill up during the lead frame
        for (int lw = 0; lw < FRAME_LEN; lw++) begin
          drive_write(lead, sample_re(base, lead, lw));
        end
      end
      for (int b = 0; b < NUM_BUF; b++) begin
        if (mask[b] && b != lead) begin
          drive_write(b, sample_re(base, b, w));
        end
      end
    end
    // Past the spare words a taken write would land on the frame
    for (int b = 0; b < NUM_BUF; b++) begin
      if (mask[b] && drop > 0) begin
        for (int d = 0; d < drop + SPARE_WORDS; d++) begin
          drive_write(b, sample_re(base, b, FRAME_LEN + 8 + d));  // Lands on a full buffer
        end
      end
    end
    @(posedge clk);
    cap_in <= '0;
    limit = 64 + (frames + 1) * (FRAME_LEN + 4) * 2;
    wait_drained(limit, drained);
    repeat (QUIET_CYCLES) @(negedge clk);
    tests_run++;
    if (!drained) begin
      $display("test %s: timed out after %0d cycles with %0d samples still expected",
               name, limit, chk_i.pending());
      tests_failed++;
      aborted = 1'b1;
    end else if (chk_i.err_cnt != err_before) begin
      $display("test %s: FAIL with %0d errors", name, chk_i.err_cnt - err_before);
      tests_failed++;
    end else begin
      $display("test %s: ok, %0d frames", name, frames);
    end
  endtask

  initial begin : main
    string       line;
    string       name;
    int          fd;
    int          n;
    int          lead;
    int          drop;
    int          g0;
    int          g1;
    int          g2;
    int          g3;
    int          grant [4];
    logic [31:0] mask_raw;
    logic [31:0] base_raw;
    tests_run    = 0;
    tests_failed = 0;
    aborted      = 1'b0;
    rst_n        = 1'b0;
    cap_in       = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("could not open the golden file %s", GOLDEN_FILE);
      aborted = 1'b1;
    end else begin
      while (!aborted && !$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if (n == 0 || line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
          continue;
        end
        n = $sscanf(line, "%s %h %h %d %h %h %h %h %h",
                    name, mask_raw, lead, drop, base_raw, g0, g1, g2, g3);
        if (n != 9) begin
          $display("golden file line could not be parsed: %s", line);
          aborted = 1'b1;
        end else begin
          grant = '{g0, g1, g2, g3};
          run_test(name, NUM_BUF'(mask_raw), lead, drop, 16'(base_raw), grant);
        end
      end
      $fclose(fd);
    end
    $display("tests run %0d, failed %0d, samples checked %0d, errors %0d",
             tests_run, tests_failed, chk_i.checked_cnt, chk_i.err_cnt);
    if (!aborted && tests_run > 0 && tests_failed == 0 && chk_i.err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
hw/prach_pkg.sv
hw/delay_line.sv
hw/prach_capture_buffer.sv
hw/prach_buffer_readout.sv
hw/prach_readout_top.sv
dv/prach_readout_checker.sv
dv/prach_readout_tb.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  -f vlog.f --top-module prach_readout_tb -o prach_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/prach_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TESTS PASSED"; then
  exit 0
else
  exit 1
fi

//--- dv/prach_golden.txt
# Columns are name, fill mask, lead buffer filled first, extra writes per full buffer,
# data base, then the expected grant order in four slots. Hex except the extra writes, f is none.
reset_idle   0 f 0 0000 f f f f
single_b1    2 f 0 0100 1 f f f
single_b3    8 f 0 1000 3 f f f
single_b0    1 f 0 0a00 0 f f f
all_four     f f 0 2000 0 1 2 3
pair_1_2     6 f 0 3000 1 2 f f
pair_0_3     9 f 0 3800 0 3 f f
refill_b1    2 f 0 4400 1 f f f
refill_all   f f 0 ffc0 0 1 2 3
late_low_0   9 3 0 5000 3 0 f f
late_low_1   3 1 0 6000 1 0 f f
late_low_2   6 2 0 6800 2 1 f f
drop_pair    c f 4 7000 2 3 f f
drop_single  1 f 3 8000 0 f f f
drop_all     f f 2 9000 0 1 2 3
final_b2     4 f 0 a000 2 f f f
